// ==== src/synth_pkg.sv ====
/* synth package
   voice, audio and CPU register widths, patch fields and waveform select */
`default_nettype none

package synth_pkg;

    localparam int VOICES = 4; // polyphony

    typedef logic [1:0]         voice_idx_t;  // voice number
    typedef logic [VOICES-1:0]  voice_mask_t; // one bit per voice
    typedef logic [6:0]         key_t;        // MIDI key number
    typedef logic [6:0]         vel_t;        // MIDI velocity
    typedef logic [11:0]        level_t;      // envelope level, max 4095
    typedef logic signed [23:0] sample_t;     // audio sample
    typedef logic [3:0]         reg_addr_t;
    typedef logic [7:0]         reg_data_t;

    typedef enum logic {
        WAVE_SAW,
        WAVE_SQUARE
    } wave_t;

    typedef struct packed {
        logic [3:0] midi_ch;      // receive channel
        wave_t      wave;
        logic [7:0] attack_rate;  // level step per sample, key held
        logic [7:0] release_rate; // level step per sample, key released
        logic [7:0] volume;       // master gain
    } patch_t;

    // CPU register map
    localparam reg_addr_t ADDR_CH      = 4'd0;
    localparam reg_addr_t ADDR_WAVE    = 4'd1;
    localparam reg_addr_t ADDR_ATTACK  = 4'd2;
    localparam reg_addr_t ADDR_RELEASE = 4'd3;
    localparam reg_addr_t ADDR_VOLUME  = 4'd4;
    localparam reg_addr_t ADDR_ACTIVE  = 4'd5; // read only

endpackage

`default_nettype wire

// ==== src/midi_pkg.sv ====
/* MIDI package
   serial bit timing, channel voice status codes, note events and parser states */
`default_nettype none

package midi_pkg;

    localparam int BIT_CYCLES = 800; // 25 MHz / 31.25 kbaud

    // upper nibble of status byte
    localparam logic [3:0] STATUS_NOTE_OFF = 4'h8;
    localparam logic [3:0] STATUS_NOTE_ON  = 4'h9;

    typedef struct packed {
        logic            on;  // 0 = note off
        synth_pkg::key_t key;
        synth_pkg::vel_t vel;
    } note_event_t;

    typedef enum logic [1:0] {
        PARSE_IDLE, // waiting for status, or first data byte under running status
        PARSE_KEY,  // status seen, key byte next
        PARSE_VEL   // key stored, velocity next
    } parse_state_t;

endpackage

`default_nettype wire

// ==== src/midi_uart_rx.sv ====
/* MIDI serial receiver
   31.25 kbaud, 8N1, one byte strobe per good stop bit */
`timescale 1ns/1ps
`default_nettype none

module midi_uart_rx (
    input  wire        reg_clk,
    input  wire        rst,
    input  wire        midi_rxd,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t  state;
    logic       rxd_meta, rxd_s; // two flop sync
    logic [9:0] cnt;             // cycles within bit
    logic [2:0] bit_idx;
    logic [7:0] shreg;
    logic       half_bit, full_bit;

    assign half_bit = cnt == 10'(midi_pkg::BIT_CYCLES / 2 - 1);
    assign full_bit = cnt == 10'(midi_pkg::BIT_CYCLES - 1);

    always_ff @(posedge reg_clk) begin
        if (rst) begin
            rxd_meta <= 1'b1; // line idles high
            rxd_s    <= 1'b1;
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rxd_meta <= midi_rxd;
            rxd_s    <= rxd_meta;
            rx_valid <= 1'b0;
            cnt      <= cnt + 10'd1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rxd_s) state <= RX_START; // falling edge
                end
                RX_START: if (half_bit) begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    state   <= rxd_s ? RX_IDLE : RX_DATA; // glitch check
                end
                RX_DATA: if (full_bit) begin
                    cnt     <= '0;
                    bit_idx <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (full_bit) begin
                    rx_valid <= rxd_s; // framing error drops the byte
                    state    <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data path, lsb first
    always_ff @(posedge reg_clk) begin
        if (state == RX_DATA && full_bit) shreg <= {rxd_s, shreg[7:1]};
        if (state == RX_STOP && full_bit) rx_byte <= shreg;
    end

endmodule

`default_nettype wire

// ==== src/midi_decoder.sv ====
/* MIDI channel voice decoder
   note on / note off parsing with running status, emits note events */
`timescale 1ns/1ps
`default_nettype none

module midi_decoder (
    input  wire                     reg_clk,
    input  wire                     rst,
    input  wire  [7:0]              rx_byte,
    input  wire                     rx_valid,
    input  wire  [3:0]              midi_ch,
    output midi_pkg::note_event_t   note_event,
    output logic                    event_valid
);

    midi_pkg::parse_state_t state;
    logic            rs_valid; // running status held
    logic            rs_on;    // held status is note on
    synth_pkg::key_t key;
    logic            is_note, is_status, is_realtime;

    assign is_status   = rx_byte[7];
    assign is_realtime = rx_byte[7:3] == 5'b11111; // F8..FF, leave status alone
    assign is_note     = (rx_byte[7:4] == midi_pkg::STATUS_NOTE_ON ||
                          rx_byte[7:4] == midi_pkg::STATUS_NOTE_OFF) &&
                         rx_byte[3:0] == midi_ch;

    always_ff @(posedge reg_clk) begin
        if (rst) begin
            state       <= midi_pkg::PARSE_IDLE;
            rs_valid    <= 1'b0;
            rs_on       <= 1'b0;
            event_valid <= 1'b0;
        end else begin
            event_valid <= 1'b0;
            if (rx_valid && is_status && !is_realtime) begin
                rs_valid <= is_note; // anything else kills running status
                rs_on    <= rx_byte[7:4] == midi_pkg::STATUS_NOTE_ON;
                state    <= is_note ? midi_pkg::PARSE_KEY : midi_pkg::PARSE_IDLE;
            end else if (rx_valid && !is_status) begin
                case (state)
                    midi_pkg::PARSE_IDLE: begin
                        if (rs_valid) state <= midi_pkg::PARSE_VEL; // running status
                    end
                    midi_pkg::PARSE_KEY: state <= midi_pkg::PARSE_VEL;
                    midi_pkg::PARSE_VEL: begin
                        event_valid <= 1'b1;
                        state       <= midi_pkg::PARSE_IDLE;
                    end
                    default: state <= midi_pkg::PARSE_IDLE;
                endcase
            end
        end
    end

    // payload, no reset
    always_ff @(posedge reg_clk) begin
        if (rx_valid && !is_status) begin
            if (state == midi_pkg::PARSE_VEL) begin
                note_event.on  <= rs_on && rx_byte[6:0] != 7'd0; // vel 0 means off
                note_event.key <= key;
                note_event.vel <= rx_byte[6:0];
            end else begin
                key <= rx_byte[6:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/voice_allocator.sv ====
/* voice allocator
   lowest free voice per note on, release by key on note off */
`timescale 1ns/1ps
`default_nettype none

module voice_allocator (
    input  wire                                          reg_clk,
    input  wire                                          rst,
    input  wire  midi_pkg::note_event_t                  note_event,
    input  wire                                          event_valid,
    input  wire  synth_pkg::voice_mask_t                 voice_free,
    output synth_pkg::voice_mask_t                       keys_on,
    output synth_pkg::key_t [synth_pkg::VOICES-1:0]      voice_keys,
    output synth_pkg::vel_t [synth_pkg::VOICES-1:0]      voice_vels,
    output logic [2:0]                                   active_count
);

    logic                  free_hit; // any voice available
    synth_pkg::voice_idx_t free_idx;

    // priority pick, lowest index wins
    always_comb begin
        free_hit = 1'b0;
        free_idx = '0;
        for (int i = synth_pkg::VOICES - 1; i >= 0; i--) begin
            if (voice_free[i]) begin
                free_hit = 1'b1;
                free_idx = synth_pkg::voice_idx_t'(i);
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (rst) begin
            keys_on    <= '0;
            voice_keys <= '0; // engine steps every voice, keep phases defined
            voice_vels <= '0;
        end else if (event_valid) begin
            if (note_event.on) begin
                if (free_hit) begin // otherwise note is dropped
                    keys_on[free_idx]    <= 1'b1;
                    voice_keys[free_idx] <= note_event.key;
                    voice_vels[free_idx] <= note_event.vel;
                end
            end else begin
                for (int i = 0; i < synth_pkg::VOICES; i++) begin
                    if (voice_keys[i] == note_event.key) keys_on[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        active_count = '0;
        for (int i = 0; i < synth_pkg::VOICES; i++) begin
            active_count = active_count + 3'(keys_on[i]);
        end
    end

endmodule

`default_nettype wire

// ==== src/patch_regs.sv ====
/* patch registers
   CPU write and readback of channel, waveform, envelope rates and volume */
`timescale 1ns/1ps
`default_nettype none

module patch_regs (
    input  wire                        reg_clk,
    input  wire                        rst,
    input  wire                        cpu_write,
    input  wire                        cpu_read,
    input  wire  synth_pkg::reg_addr_t address,
    input  wire  synth_pkg::reg_data_t cpu_wdata,
    input  wire  [2:0]                 active_count,
    output synth_pkg::reg_data_t       cpu_rdata,
    output synth_pkg::patch_t          patch
);

    always_ff @(posedge reg_clk) begin
        if (rst) begin
            patch.midi_ch      <= '0;
            patch.wave         <= synth_pkg::WAVE_SQUARE;
            patch.attack_rate  <= 8'hff;
            patch.release_rate <= 8'hff;
            patch.volume       <= 8'hff;
            cpu_rdata          <= '0;
        end else begin
            if (cpu_write) begin
                case (address)
                    synth_pkg::ADDR_CH:      patch.midi_ch      <= cpu_wdata[3:0];
                    synth_pkg::ADDR_WAVE:    patch.wave <= synth_pkg::wave_t'(cpu_wdata[0]);
                    synth_pkg::ADDR_ATTACK:  patch.attack_rate  <= cpu_wdata;
                    synth_pkg::ADDR_RELEASE: patch.release_rate <= cpu_wdata;
                    synth_pkg::ADDR_VOLUME:  patch.volume       <= cpu_wdata;
                    default: ;                                  // read only or unused
                endcase
            end
            if (cpu_read) begin // held until next read
                case (address)
                    synth_pkg::ADDR_CH:      cpu_rdata <= {4'd0, patch.midi_ch};
                    synth_pkg::ADDR_WAVE:    cpu_rdata <= {7'd0, patch.wave};
                    synth_pkg::ADDR_ATTACK:  cpu_rdata <= patch.attack_rate;
                    synth_pkg::ADDR_RELEASE: cpu_rdata <= patch.release_rate;
                    synth_pkg::ADDR_VOLUME:  cpu_rdata <= patch.volume;
                    synth_pkg::ADDR_ACTIVE:  cpu_rdata <= {5'd0, active_count};
                    default:                 cpu_rdata <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/synth_engine.sv ====
/* synth engine
   one voice per cycle, phase accumulator, linear AR envelope, stereo mix */
`timescale 1ns/1ps
`default_nettype none

module synth_engine (
    input  wire                                     reg_clk,
    input  wire                                     rst,
    input  wire                                     trig,
    input  wire  synth_pkg::patch_t                 patch,
    input  wire  synth_pkg::voice_mask_t            keys_on,
    input  wire  synth_pkg::key_t [synth_pkg::VOICES-1:0] voice_keys,
    input  wire  synth_pkg::vel_t [synth_pkg::VOICES-1:0] voice_vels,
    output synth_pkg::voice_mask_t                  voice_free,
    output synth_pkg::sample_t                      lsound_out,
    output synth_pkg::sample_t                      rsound_out,
    output logic                                    sample_valid
);

    logic                  busy;                          // pass in progress
    logic [2:0]            step;                          // 0..3 voices, 4 mix
    logic [15:0]           phase [synth_pkg::VOICES];
    synth_pkg::level_t     level [synth_pkg::VOICES];
    logic signed [31:0]    lacc, racc;                    // even / odd voice sums
    synth_pkg::voice_idx_t v;
    logic [15:0]           phase_next;
    logic [12:0]           attack_sum;
    synth_pkg::level_t     level_next;
    logic signed [15:0]    wave;
    logic signed [31:0]    term;
    logic signed [39:0]    lmix, rmix;

    ////////////////////////////////////////////////////////////
    // per voice datapath
    ////////////////////////////////////////////////////////////

    assign v          = step[1:0];
    assign phase_next = phase[v] + {6'd0, voice_keys[v], 3'd0}; // key x 8
    assign attack_sum = {1'b0, level[v]} + {5'd0, patch.attack_rate};

    always_comb begin
        if (keys_on[v])
            level_next = attack_sum[12] ? 12'hfff : attack_sum[11:0]; // clamp high
        else if (level[v] > {4'd0, patch.release_rate})
            level_next = level[v] - {4'd0, patch.release_rate};
        else
            level_next = '0;                                        // clamp low
    end

    always_comb begin
        if (patch.wave == synth_pkg::WAVE_SAW)
            wave = $signed(phase_next);
        else
            wave = phase_next[15] ? 16'sh8000 : 16'sh7fff;
    end

    // wave x level top byte x velocity, fits 32 bits signed
    assign term = wave * $signed({1'b0, level_next[11:4]}) * $signed({1'b0, voice_vels[v]});

    assign lmix = lacc * $signed({1'b0, patch.volume});
    assign rmix = racc * $signed({1'b0, patch.volume});

    always_comb begin
        for (int i = 0; i < synth_pkg::VOICES; i++) begin
            voice_free[i] = !keys_on[i] && level[i] == '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge reg_clk) begin
        if (rst) begin
            busy         <= 1'b0;
            step         <= '0;
            lacc         <= '0;
            racc         <= '0;
            sample_valid <= 1'b0;
            lsound_out   <= '0;
            rsound_out   <= '0;
            for (int i = 0; i < synth_pkg::VOICES; i++) begin
                phase[i] <= '0;
                level[i] <= '0;
            end
        end else begin
            sample_valid <= 1'b0;
            if (!busy) begin
                if (trig) begin // new pass
                    busy <= 1'b1;
                    step <= '0;
                    lacc <= '0;
                    racc <= '0;
                end
            end else if (step != 3'(synth_pkg::VOICES)) begin
                phase[v] <= phase_next;
                level[v] <= level_next;
                if (v[0]) racc <= racc + term; // odd to right
                else      lacc <= lacc + term;
                step <= step + 3'd1;
            end else begin // final cycle, apply master volume
                lsound_out   <= lmix[39:16];
                rsound_out   <= rmix[39:16];
                sample_valid <= 1'b1;
                busy         <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/synthesizer.sv ====
/* MIDI polyphonic synthesizer top
   serial MIDI in, four voices, stereo 24 bit samples, CPU patch port */
`timescale 1ns/1ps
`default_nettype none

module synthesizer (
    input  wire                        reg_clk,
    input  wire                        rst,
    input  wire                        midi_rxd,
    input  wire                        trig,
    input  wire                        cpu_write,
    input  wire                        cpu_read,
    input  wire  synth_pkg::reg_addr_t address,
    input  wire  synth_pkg::reg_data_t cpu_wdata,
    output synth_pkg::reg_data_t       cpu_rdata,
    output synth_pkg::voice_mask_t     keys_on,
    output synth_pkg::voice_mask_t     voice_free,
    output synth_pkg::sample_t         lsound_out,
    output synth_pkg::sample_t         rsound_out,
    output logic                       sample_valid
);

    logic [7:0]                                rx_byte;
    logic                                      rx_valid;
    midi_pkg::note_event_t                     note_event;
    logic                                      event_valid;
    synth_pkg::key_t [synth_pkg::VOICES-1:0]   voice_keys;
    synth_pkg::vel_t [synth_pkg::VOICES-1:0]   voice_vels;
    logic [2:0]                                active_count;
    synth_pkg::patch_t                         patch;

    ////////////////////////////////////////////////////////////
    // MIDI in
    ////////////////////////////////////////////////////////////

    midi_uart_rx midi_uart_rx_inst (
        .reg_clk      (reg_clk),
        .rst          (rst),
        .midi_rxd     (midi_rxd),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid)      // mid stop bit
    );

    midi_decoder midi_decoder_inst (
        .reg_clk      (reg_clk),
        .rst          (rst),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .midi_ch      (patch.midi_ch),
        .note_event   (note_event),
        .event_valid  (event_valid)
    );

    voice_allocator voice_allocator_inst (
        .reg_clk      (reg_clk),
        .rst          (rst),
        .note_event   (note_event),
        .event_valid  (event_valid),
        .voice_free   (voice_free),   // from envelopes
        .keys_on      (keys_on),
        .voice_keys   (voice_keys),
        .voice_vels   (voice_vels),
        .active_count (active_count)
    );

    ////////////////////////////////////////////////////////////
    // control and sound
    ////////////////////////////////////////////////////////////

    patch_regs patch_regs_inst (
        .reg_clk      (reg_clk),
        .rst          (rst),
        .cpu_write    (cpu_write),
        .cpu_read     (cpu_read),
        .address      (address),
        .cpu_wdata    (cpu_wdata),
        .active_count (active_count),
        .cpu_rdata    (cpu_rdata),
        .patch        (patch)
    );

    synth_engine synth_engine_inst (
        .reg_clk      (reg_clk),
        .rst          (rst),
        .trig         (trig),
        .patch        (patch),
        .keys_on      (keys_on),
        .voice_keys   (voice_keys),
        .voice_vels   (voice_vels),
        .voice_free   (voice_free),
        .lsound_out   (lsound_out),
        .rsound_out   (rsound_out),
        .sample_valid (sample_valid)  // trig + 6
    );

endmodule

`default_nettype wire

// ==== dv/tb_synthesizer.sv ====
/* synthesizer testbench
   MIDI and CPU stimulus, trig passes, assertion checks on keys, registers and audio */
`timescale 1ns/1ps
`default_nettype none

module tb_synthesizer;

    // 41 MIDI bytes of 10 bits, margin covers CPU and trig traffic
    localparam int BYTES_SENT  = 41;
    localparam int CYCLE_LIMIT = BYTES_SENT * 10 * midi_pkg::BIT_CYCLES + 20000;

    logic                   reg_clk = 1'b0;
    logic                   rst;
    logic                   midi_rxd;
    logic                   trig;
    logic                   cpu_write;
    logic                   cpu_read;
    synth_pkg::reg_addr_t   address;
    synth_pkg::reg_data_t   cpu_wdata;
    synth_pkg::reg_data_t   cpu_rdata;
    synth_pkg::voice_mask_t keys_on;
    synth_pkg::voice_mask_t voice_free;
    synth_pkg::sample_t     lsound_out;
    synth_pkg::sample_t     rsound_out;
    logic                   sample_valid;

    logic [15:0] lfsr;       // velocity source
    int          cycles = 0; // run length so far

    synthesizer i_synthesizer (
        .reg_clk      (reg_clk),
        .rst          (rst),
        .midi_rxd     (midi_rxd),
        .trig         (trig),
        .cpu_write    (cpu_write),
        .cpu_read     (cpu_read),
        .address      (address),
        .cpu_wdata    (cpu_wdata),
        .cpu_rdata    (cpu_rdata),
        .keys_on      (keys_on),
        .voice_free   (voice_free),
        .lsound_out   (lsound_out),
        .rsound_out   (rsound_out),
        .sample_valid (sample_valid)
    );

    always #20 reg_clk = ~reg_clk; // 40 ns period

    always @(posedge reg_clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            abort_run("timeout, the run went past its cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////
    // reporting and random source
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("error at %0d ns: %s", $time, reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input longint got, input longint exp);
        $display("error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // 16 bit Galois, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic rand_vel(output synth_pkg::vel_t vel);
        vel = '0;
        for (int i = 0; i < 7; i++) begin
            vel  = {vel[5:0], lfsr[0]}; // one step per bit
            lfsr = lfsr_next(lfsr);
        end
        if (vel == '0) vel = 7'd1; // zero would turn a note on into a note off
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge reg_clk);
        #2; // inputs move just after the edge
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0}; // stop, data lsb first, start
        for (int i = 0; i < 10; i++) begin
            midi_rxd = frame[i];
            repeat (midi_pkg::BIT_CYCLES) next_cycle();
        end
    endtask

    task automatic send_msg(input logic [7:0] status, input logic [7:0] key,
                            input logic [7:0] vel);
        send_byte(status);
        send_byte(key);
        send_byte(vel);
    endtask

    task automatic write_reg(input synth_pkg::reg_addr_t addr, input synth_pkg::reg_data_t data);
        cpu_write = 1'b1;
        address   = addr;
        cpu_wdata = data;
        next_cycle();
        cpu_write = 1'b0;
    endtask

    // data one cycle after the read strobe, then held
    task automatic read_reg(input synth_pkg::reg_addr_t addr, input synth_pkg::reg_data_t exp);
        cpu_read = 1'b1;
        address  = addr;
        next_cycle();
        cpu_read = 1'b0;
        assert (cpu_rdata == exp) else value_error("cpu_rdata", cpu_rdata, exp);
        next_cycle();
        assert (cpu_rdata == exp) else value_error("cpu_rdata held", cpu_rdata, exp);
    endtask

    task automatic assert_keys(input synth_pkg::voice_mask_t exp);
        assert (keys_on == exp) else value_error("keys_on", keys_on, exp);
    endtask

    // one engine pass, returns while sample_valid is high
    task automatic pulse_trig();
        int waited;
        trig = 1'b1;
        next_cycle();
        trig   = 1'b0;
        waited = 0;
        while (!sample_valid && waited < 20) begin
            next_cycle();
            waited++;
        end
        assert (sample_valid) else abort_run("no sample_valid after trig");
    endtask

    ////////////////////////////////////////////////////////////
    // protocol checks
    ////////////////////////////////////////////////////////////

    assert property (@(posedge reg_clk) disable iff (rst) sample_valid == $past(trig, 6))
        else abort_run("sample_valid did not come exactly 6 cycles after trig");

    assert property (@(posedge reg_clk) disable iff (rst)
                     !sample_valid |-> $stable(lsound_out) && $stable(rsound_out))
        else abort_run("audio outputs changed without sample_valid");

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        synth_pkg::vel_t        vel_a;
        synth_pkg::vel_t        vel;
        synth_pkg::voice_mask_t exp_mask;
        logic [15:0]            phase_exp;
        longint                 wave_exp;
        longint                 peak;
        int                     passes;

        rst       = 1'b1;
        midi_rxd  = 1'b1; // idle line
        trig      = 1'b0;
        cpu_write = 1'b0;
        cpu_read  = 1'b0;
        address   = '0;
        cpu_wdata = '0;
        lfsr      = 16'd17;
        repeat (5) @(posedge reg_clk);
        #2;
        rst = 1'b0;

        assert_keys(4'h0);
        assert (voice_free == 4'hf) else value_error("voice_free", voice_free, 4'hf);
        assert (lsound_out == '0) else value_error("lsound_out", lsound_out, 0);
        assert (rsound_out == '0) else value_error("rsound_out", rsound_out, 0);
        assert (!sample_valid) else value_error("sample_valid", sample_valid, 0);
        read_reg(synth_pkg::ADDR_WAVE, 8'(synth_pkg::WAVE_SQUARE));
        read_reg(synth_pkg::ADDR_VOLUME, 8'd255);

        // patch registers
        write_reg(synth_pkg::ADDR_ATTACK, 8'd17);
        read_reg(synth_pkg::ADDR_ATTACK, 8'd17); // differs from the reset value
        write_reg(synth_pkg::ADDR_CH, 8'd3);
        write_reg(synth_pkg::ADDR_WAVE, 8'(synth_pkg::WAVE_SAW));
        write_reg(synth_pkg::ADDR_ATTACK, 8'd255);
        write_reg(synth_pkg::ADDR_RELEASE, 8'd128);
        write_reg(synth_pkg::ADDR_VOLUME, 8'd200);
        read_reg(synth_pkg::ADDR_CH, 8'd3);
        read_reg(synth_pkg::ADDR_WAVE, 8'(synth_pkg::WAVE_SAW));
        read_reg(synth_pkg::ADDR_ATTACK, 8'd255);
        read_reg(synth_pkg::ADDR_RELEASE, 8'd128);
        read_reg(synth_pkg::ADDR_VOLUME, 8'd200);
        read_reg(synth_pkg::ADDR_ACTIVE, 8'd0);

        // silence with every voice free
        pulse_trig();
        assert (lsound_out == '0) else value_error("lsound_out", lsound_out, 0);
        assert (rsound_out == '0) else value_error("rsound_out", rsound_out, 0);
        assert (voice_free == 4'hf) else value_error("voice_free", voice_free, 4'hf);

        // note assignment and running status
        rand_vel(vel);
        send_msg(8'h93, 8'd60, 8'(vel));
        assert_keys(4'b0001);
        rand_vel(vel);
        send_byte(8'd64); // data only, status 0x93 still held
        send_byte(8'(vel));
        assert_keys(4'b0011);
        rand_vel(vel);
        send_msg(8'h95, 8'd67, 8'(vel)); // other channel
        assert_keys(4'b0011);
        send_byte(8'd69); // orphan data after a foreign status
        send_byte(8'(vel));
        assert_keys(4'b0011);
        read_reg(synth_pkg::ADDR_ACTIVE, 8'd2);

        // note off, both forms
        send_msg(8'h93, 8'd60, 8'd0);
        assert_keys(4'b0010);
        read_reg(synth_pkg::ADDR_ACTIVE, 8'd1);
        send_msg(8'h83, 8'd64, 8'h40);
        assert_keys(4'b0000);
        read_reg(synth_pkg::ADDR_ACTIVE, 8'd0);

        // five notes on four voices, last one dropped
        send_byte(8'h93);
        for (int k = 0; k < 5; k++) begin
            rand_vel(vel);
            send_byte(8'(70 + 2 * k));
            send_byte(8'(vel));
            exp_mask = (k < 4) ? synth_pkg::voice_mask_t'((1 << (k + 1)) - 1) : 4'hf;
            assert_keys(exp_mask);
        end
        read_reg(synth_pkg::ADDR_ACTIVE, 8'd4);
        send_byte(8'h83);
        for (int k = 0; k < 4; k++) begin
            send_byte(8'(70 + 2 * k));
            send_byte(8'h40);
        end
        assert_keys(4'h0);
        assert (voice_free == 4'hf) else value_error("voice_free", voice_free, 4'hf);

        // held voice 0 at full level, square wave
        write_reg(synth_pkg::ADDR_WAVE, 8'(synth_pkg::WAVE_SQUARE));
        rand_vel(vel_a);
        send_msg(8'h93, 8'd60, 8'(vel_a));
        assert_keys(4'b0001);
        repeat (20) pulse_trig(); // 17 attack steps reach 4095
        // voice 0 phase, only the 20 passes with key 60 moved it
        phase_exp = 16'(20 * 60 * 8);
        wave_exp  = phase_exp[15] ? -32768 : 32767;
        // square x level byte 255 x velocity x volume 200, top 24 of 40
        peak      = (wave_exp * 255 * longint'(vel_a) * 200) >>> 16;
        assert (longint'(lsound_out) == peak) else value_error("lsound_out", lsound_out, peak);
        assert (rsound_out == '0) else value_error("rsound_out", rsound_out, 0);
        assert (voice_free == 4'b1110) else value_error("voice_free", voice_free, 4'b1110);

        // release until the envelope is back at zero
        send_byte(8'd60);
        send_byte(8'd0);
        assert_keys(4'h0);
        passes = 0;
        while (voice_free != 4'hf && passes < 40) begin
            pulse_trig();
            passes++;
        end
        assert (voice_free == 4'hf) else value_error("voice_free", voice_free, 4'hf);
        assert (lsound_out == '0) else value_error("lsound_out", lsound_out, 0);
        assert (rsound_out == '0) else value_error("rsound_out", rsound_out, 0);
        pulse_trig();
        assert (lsound_out == '0) else value_error("lsound_out", lsound_out, 0);
        assert (rsound_out == '0) else value_error("rsound_out", rsound_out, 0);

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/synth_pkg.sv
src/midi_pkg.sv
src/midi_uart_rx.sv
src/midi_decoder.sv
src/voice_allocator.sv
src/patch_regs.sv
src/synth_engine.sv
src/synthesizer.sv
dv/tb_synthesizer.sv

// ==== Makefile ====
# Verilator flow for the MIDI synthesizer testbench

TOP = tb_synthesizer

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
